/* src/loader_pkg.sv */
`default_nettype none

package loader_pkg;

    // ----------------------------------------
    // data widths
    // ----------------------------------------

    // one memory word
    parameter int NB_DATA = 32;

    // one byte on the host link
    parameter int NB_BYTE = 8;

    // bytes packed into each word, lsb first
    parameter int BYTES_PER_WORD = NB_DATA / NB_BYTE;

    // ----------------------------------------
    // boot image
    // ----------------------------------------

    // entries preloaded at reset
    parameter int BOOT_WORDS = 12;

    // reset contents of addresses 0 to BOOT_WORDS-1
    parameter logic [NB_DATA-1:0] boot_image [0:BOOT_WORDS-1] = '{
        32'h0C0F_FEE0,
        32'h1357_9BDF,
        32'h2468_ACE0,
        32'h3A3A_5C5C,
        32'h4000_0001,
        32'h5EED_5EED,
        32'h6B6B_1212,
        32'h7F7F_0808,
        32'h8001_8001,
        32'h9C9C_3636,
        32'hA5A5_5A5A,
        32'hBEEF_0042
    };

    // ----------------------------------------
    // controller state
    // ----------------------------------------

    // idle until start, loading until count reaches length
    typedef enum logic [0:0] {
        IDLE,
        LOADING
    } load_state_t;

endpackage

`default_nettype wire

/* src/word_assembler.sv */
`default_nettype none
`timescale 1ns/10ps

module word_assembler (
    input  wire                            i_clock,
    input  wire                            i_reset,
    // four-phase byte link, slave side
    input  wire                            i_byte_req,
    input  wire [loader_pkg::NB_BYTE-1:0]  i_byte_data,
    output wire                            o_byte_ack,
    // assembled word towards memory
    output wire [loader_pkg::NB_DATA-1:0]  o_word_data,
    output wire                            o_word_valid
);

    import loader_pkg::*;

    // byte position counter width
    localparam int NB_COUNT = $clog2(BYTES_PER_WORD);

    // position of the byte that completes a word
    localparam logic [NB_COUNT-1:0] LAST_BYTE = NB_COUNT'(BYTES_PER_WORD - 1);

    logic                  byte_ack;
    logic [NB_COUNT-1:0]   byte_count;
    logic [NB_DATA-1:0]    word_reg;
    logic                  word_valid;

    // req seen high with ack still low, phase 1 -> 2
    logic                  byte_accept;
    // req seen low with ack still high, phase 3 -> 4
    logic                  byte_release;

    assign byte_accept  = i_byte_req && !byte_ack;
    assign byte_release = !i_byte_req && byte_ack;

    // ----------------------------------------
    // handshake
    // ----------------------------------------

    // ack follows req one edge late
    // host holds the byte stable until ack rises
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            byte_ack <= 1'b0;
        end else if (byte_accept) begin
            byte_ack <= 1'b1;
        end else if (byte_release) begin
            byte_ack <= 1'b0;
        end
    end

    // ----------------------------------------
    // byte packing
    // ----------------------------------------

    // counts accepted bytes, wraps after the last one of a word
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            byte_count <= '0;
        end else if (byte_accept) begin
            if (byte_count == LAST_BYTE) begin
                byte_count <= '0;
            end else begin
                byte_count <= byte_count + NB_COUNT'(1);
            end
        end
    end

    // first byte lands in the low lane
    // older lanes are kept until overwritten by the next word
    always_ff @(posedge i_clock) begin
        if (byte_accept) begin
            word_reg[byte_count*NB_BYTE +: NB_BYTE] <= i_byte_data;
        end
    end

    // one-cycle strobe, same edge as ack for the last byte
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            word_valid <= 1'b0;
        end else begin
            word_valid <= byte_accept && (byte_count == LAST_BYTE);
        end
    end

    // ----------------------------------------
    // outputs
    // ----------------------------------------

    assign o_byte_ack   = byte_ack;
    assign o_word_data  = word_reg;
    assign o_word_valid = word_valid;

endmodule

`default_nettype wire

/* src/load_controller.sv */
`default_nettype none
`timescale 1ns/10ps

module load_controller #(
    parameter int NB_ADDRESS = 8
) (
    input  wire                   i_clock,
    input  wire                   i_reset,
    // session request
    input  wire                   i_load_start,
    input  wire [NB_ADDRESS:0]    i_load_length,
    // words written so far, from memory
    input  wire [NB_ADDRESS:0]    i_write_count,
    // session status
    output wire                   o_write_enable,
    output wire                   o_load_busy,
    output wire                   o_load_done
);

    import loader_pkg::*;

    load_state_t               state;
    load_state_t               state_next;

    // length requested at start
    logic [NB_ADDRESS:0]       length_q;

    // high from the second loading cycle on
    logic                      armed;

    logic                      count_reached;
    logic                      load_done;

    // ----------------------------------------
    // session end detect
    // ----------------------------------------

    // memory clears its count one edge after enable rises
    // so the first loading cycle may still see last session's count
    assign count_reached = armed && (i_write_count == length_q);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            armed <= 1'b0;
        end else begin
            armed <= (state == LOADING);
        end
    end

    always_ff @(posedge i_clock) begin
        if ((state == IDLE) && i_load_start) begin
            length_q <= i_load_length;
        end
    end

    // ----------------------------------------
    // state machine
    // ----------------------------------------

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (i_load_start) begin
                    state_next = LOADING;
                end
            end
            LOADING: begin
                if (count_reached) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // single pulse on the way back to idle
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            load_done <= 1'b0;
        end else begin
            load_done <= (state == LOADING) && count_reached;
        end
    end

    // ----------------------------------------
    // outputs
    // ----------------------------------------

    assign o_write_enable = (state == LOADING);
    assign o_load_busy    = (state == LOADING);
    assign o_load_done    = load_done;

endmodule

`default_nettype wire

/* src/ram_memory.sv */
`default_nettype none
`timescale 1ns/10ps

module ram_memory #(
    parameter int NB_DATA    = loader_pkg::NB_DATA,
    parameter int RAM_DEPTH  = 256,
    parameter int NB_ADDRESS = 8
) (
    input  wire                    i_clock,
    input  wire                    i_reset,
    // combinational read port
    input  wire [NB_ADDRESS-1:0]   i_read_address,
    output wire [NB_DATA-1:0]      o_read_data,
    // write side, address is internal
    input  wire [NB_DATA-1:0]      i_write_data,
    input  wire                    i_write_enable,
    input  wire                    i_write_data_next,
    // words written this session
    output wire [NB_ADDRESS:0]     o_write_count
);

    import loader_pkg::*;

    logic [NB_DATA-1:0]     memory [0:RAM_DEPTH-1];
    logic [NB_ADDRESS-1:0]  write_address;
    logic [NB_ADDRESS:0]    write_count;

    // registered copy of the session enable
    logic                   write_enable_q;

    logic                   session_restart;
    logic                   write_strobe;

    // enable high now, low in the registered copy
    assign session_restart = i_write_enable && !write_enable_q;
    assign write_strobe    = write_enable_q && i_write_data_next;

    // ----------------------------------------
    // write address and count
    // ----------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            write_enable_q <= 1'b0;
        end else begin
            write_enable_q <= i_write_enable;
        end
    end

    // restart wins over a coincident strobe
    always_ff @(posedge i_clock) begin
        if (i_reset || session_restart) begin
            write_address <= '0;
            write_count   <= '0;
        end else if (write_strobe) begin
            write_address <= write_address + NB_ADDRESS'(1);
            write_count   <= write_count + (NB_ADDRESS + 1)'(1);
        end
    end

    // ----------------------------------------
    // storage
    // ----------------------------------------

    // boot image in the low entries, the rest keeps whatever it had
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < BOOT_WORDS; i++) begin
                memory[i] <= boot_image[i];
            end
        end else if (write_strobe) begin
            memory[write_address] <= i_write_data;
        end
    end

    // ----------------------------------------
    // outputs
    // ----------------------------------------

    assign o_read_data   = memory[i_read_address];
    assign o_write_count = write_count;

endmodule

`default_nettype wire

/* src/program_loader_top.sv */
`default_nettype none
`timescale 1ns/10ps

module program_loader_top #(
    parameter int RAM_DEPTH  = 256,
    parameter int NB_ADDRESS = 8
) (
    input  wire                            i_clock,
    input  wire                            i_reset,
    // byte link from the host
    input  wire                            i_byte_req,
    input  wire [loader_pkg::NB_BYTE-1:0]  i_byte_data,
    output wire                            o_byte_ack,
    // load session
    input  wire                            i_load_start,
    input  wire [NB_ADDRESS:0]             i_load_length,
    output wire                            o_load_busy,
    output wire                            o_load_done,
    // read port
    input  wire [NB_ADDRESS-1:0]           i_read_address,
    output wire [loader_pkg::NB_DATA-1:0]  o_read_data
);

    import loader_pkg::*;

    // assembler to memory
    logic [NB_DATA-1:0]   word_data;
    logic                 word_valid;

    // controller and memory loop
    logic                 write_enable;
    logic [NB_ADDRESS:0]  write_count;

    // ----------------------------------------
    // byte link
    // ----------------------------------------

    word_assembler u_word_assembler (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_byte_req   (i_byte_req),
        .i_byte_data  (i_byte_data),
        .o_byte_ack   (o_byte_ack),
        .o_word_data  (word_data),
        .o_word_valid (word_valid)
    );

    // ----------------------------------------
    // session control
    // ----------------------------------------

    load_controller #(
        .NB_ADDRESS (NB_ADDRESS)
    ) u_load_controller (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_load_start   (i_load_start),
        .i_load_length  (i_load_length),
        .i_write_count  (write_count),
        .o_write_enable (write_enable),
        .o_load_busy    (o_load_busy),
        .o_load_done    (o_load_done)
    );

    // ----------------------------------------
    // word memory
    // ----------------------------------------

    // word_valid doubles as the next-address pulse
    ram_memory #(
        .NB_DATA    (NB_DATA),
        .RAM_DEPTH  (RAM_DEPTH),
        .NB_ADDRESS (NB_ADDRESS)
    ) u_ram_memory (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_read_address    (i_read_address),
        .o_read_data       (o_read_data),
        .i_write_data      (word_data),
        .i_write_enable    (write_enable),
        .i_write_data_next (word_valid),
        .o_write_count     (write_count)
    );

endmodule

`default_nettype wire

/* verification/tb_program_loader.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_program_loader;

    import loader_pkg::*;

    localparam int RAM_DEPTH   = 256;
    localparam int NB_ADDRESS  = 8;
    localparam int NB_LENGTH   = NB_ADDRESS + 1;
    localparam int NUM_TESTS   = 5;
    localparam int FIXED_WORDS = 10;
    // cycles allowed for one handshake phase or a status change
    localparam int WAIT_LIMIT  = 40;

    // ----------------------------------------
    // test table
    // ----------------------------------------

    // reset check, 5-word load, 3-word reload, bytes with no session, full depth
    localparam int T_SESSION [NUM_TESTS] = '{0, 1, 1, 0, 1};
    localparam int T_WORDS   [NUM_TESTS] = '{0, 5, 3, 2, RAM_DEPTH};
    localparam int T_OFFSET  [NUM_TESTS] = '{0, 0, 5, 8, FIXED_WORDS};
    localparam int T_READ_LO [NUM_TESTS] = '{0, 0, 0, 0, 0};
    localparam int T_READ_HI [NUM_TESTS] = '{11, 11, 11, 11, RAM_DEPTH - 1};

    logic                   clock;
    logic                   reset;
    logic                   byte_req;
    logic [NB_BYTE-1:0]     byte_data;
    wire                    byte_ack;
    logic                   load_start;
    logic [NB_LENGTH-1:0]   load_length;
    wire                    load_busy;
    wire                    load_done;
    logic [NB_ADDRESS-1:0]  read_address;
    wire  [NB_DATA-1:0]     read_data;

    // words sent by all tests, and the expected memory contents
    logic [NB_DATA-1:0]     word_table [0:FIXED_WORDS+RAM_DEPTH-1];
    logic [NB_DATA-1:0]     model_mem [0:RAM_DEPTH-1];

    integer seed = 94306;
    int     test_errors;
    int     total_errors = 0;
    int     tests_failed = 0;

    // running counts from the link monitor
    int     ack_rises = 0;
    int     ack_falls = 0;
    int     done_pulses = 0;
    int     rises_at_done = 0;
    logic   ack_prev = 1'b0;

    program_loader_top #(
        .RAM_DEPTH  (RAM_DEPTH),
        .NB_ADDRESS (NB_ADDRESS)
    ) dut0 (
        .i_clock        (clock),
        .i_reset        (reset),
        .i_byte_req     (byte_req),
        .i_byte_data    (byte_data),
        .o_byte_ack     (byte_ack),
        .i_load_start   (load_start),
        .i_load_length  (load_length),
        .o_load_busy    (load_busy),
        .o_load_done    (load_done),
        .i_read_address (read_address),
        .o_read_data    (read_data)
    );

    always #5 clock = ~clock;

    // counts ack edges and done pulses on the falling edge
    always @(negedge clock) begin
        if (byte_ack && !ack_prev) ack_rises++;
        if (!byte_ack && ack_prev) ack_falls++;
        if (load_done) begin
            done_pulses++;
            rises_at_done = ack_rises;
        end
        ack_prev = byte_ack;
    end

    function automatic int total_words();
        int sum;
        sum = 0;
        for (int t = 0; t < NUM_TESTS; t++) sum += T_WORDS[t];
        return sum;
    endfunction

    // watchdog sized from the byte count of the table
    initial begin
        int limit;
        limit = total_words() * BYTES_PER_WORD * 40 + 2000;
        repeat (limit) @(posedge clock);
        $display("watchdog expired after %0d cycles, run did not finish", limit);
        $display("Test failures found");
        $finish;
    end

    // ----------------------------------------
    // host driver
    // ----------------------------------------

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    // random 0 to 3 cycle gap before a req edge
    task automatic random_gap();
        int n;
        n = $random(seed) & 3;
        repeat (n) next_cycle();
    endtask

    task automatic wait_ack_level(input logic level);
        int cycles;
        cycles = 0;
        while (byte_ack !== level && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        assert (byte_ack === level) else begin
            $display("handshake stalled at %0t: ack never went to %0b", $time, level);
            test_errors++;
        end
    endtask

    task automatic send_byte(input logic [NB_BYTE-1:0] value);
        random_gap();
        byte_data = value;
        byte_req  = 1'b1;
        wait_ack_level(1'b1);
        random_gap();
        byte_req = 1'b0;
        wait_ack_level(1'b0);
    endtask

    // lsb first
    task automatic send_word(input logic [NB_DATA-1:0] value);
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            send_byte(value[b*NB_BYTE +: NB_BYTE]);
        end
    endtask

    task automatic start_session(input int words);
        int cycles;
        cycles = 0;
        load_length = NB_LENGTH'(words);
        load_start  = 1'b1;
        next_cycle();
        load_start = 1'b0;
        while (!load_busy && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        assert (load_busy) else begin
            $display("busy did not rise after start at %0t", $time);
            test_errors++;
        end
    endtask

    task automatic wait_done(input int done_base);
        int cycles;
        cycles = 0;
        while (done_pulses == done_base && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        assert (done_pulses != done_base) else begin
            $display("done never pulsed at end of session, time %0t", $time);
            test_errors++;
        end
    endtask

    // reads one address per cycle
    task automatic read_back(input int lo, input int hi);
        for (int a = lo; a <= hi; a++) begin
            read_address = NB_ADDRESS'(a);
            @(negedge clock);
            assert (read_data === model_mem[a]) else begin
                $display("Mismatch at %0t: address %0d read %h, expected %h",
                         $time, a, read_data, model_mem[a]);
                test_errors++;
            end
            next_cycle();
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------

    initial begin
        int rises_base;
        int falls_base;
        int done_base;
        int bytes;
        clock        = 1'b0;
        reset        = 1'b1;
        byte_req     = 1'b0;
        byte_data    = '0;
        load_start   = 1'b0;
        load_length  = '0;
        read_address = '0;

        // hand-picked words for the short sessions, random fill for full depth
        word_table[0] = 32'h0403_0201;
        word_table[1] = 32'h8877_6655;
        word_table[2] = 32'hDEAD_BEEF;
        word_table[3] = 32'h0000_00FF;
        word_table[4] = 32'hFF00_0000;
        word_table[5] = 32'h1111_2222;
        word_table[6] = 32'h3333_4444;
        word_table[7] = 32'hCAFE_F00D;
        word_table[8] = 32'hBAD0_BAD0;
        word_table[9] = 32'h7777_7777;
        for (int i = FIXED_WORDS; i < FIXED_WORDS + RAM_DEPTH; i++) begin
            word_table[i] = $random(seed);
        end
        for (int i = 0; i < RAM_DEPTH; i++) model_mem[i] = 'x;
        for (int i = 0; i < BOOT_WORDS; i++) model_mem[i] = boot_image[i];

        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;
        next_cycle();

        for (int t = 0; t < NUM_TESTS; t++) begin
            test_errors = 0;
            bytes       = T_WORDS[t] * BYTES_PER_WORD;
            rises_base  = ack_rises;
            falls_base  = ack_falls;
            done_base   = done_pulses;

            if (T_SESSION[t] != 0) begin
                start_session(T_WORDS[t]);
            end else begin
                assert (!load_busy && !load_done) else begin
                    $display("busy or done high with no session open at %0t", $time);
                    test_errors++;
                end
            end

            for (int w = 0; w < T_WORDS[t]; w++) send_word(word_table[T_OFFSET[t] + w]);

            if (T_SESSION[t] != 0) begin
                wait_done(done_base);
                repeat (4) next_cycle();
                assert (done_pulses - done_base == 1) else begin
                    $display("Mismatch at %0t: done pulsed %0d times in one session",
                             $time, done_pulses - done_base);
                    test_errors++;
                end
                // done must follow the ack of the last byte
                assert (rises_at_done - rises_base == bytes) else begin
                    $display("Mismatch at %0t: done came after %0d of %0d acks",
                             $time, rises_at_done - rises_base, bytes);
                    test_errors++;
                end
                assert (!load_busy) else begin
                    $display("busy still high after done at %0t", $time);
                    test_errors++;
                end
                for (int w = 0; w < T_WORDS[t]; w++) model_mem[w] = word_table[T_OFFSET[t] + w];
            end else begin
                repeat (4) next_cycle();
                assert (done_pulses == done_base) else begin
                    $display("done pulsed with no session open at %0t", $time);
                    test_errors++;
                end
            end

            assert (ack_rises - rises_base == bytes && ack_falls - falls_base == bytes) else begin
                $display("Mismatch at %0t: ack rose %0d and fell %0d times for %0d bytes",
                         $time, ack_rises - rises_base, ack_falls - falls_base, bytes);
                test_errors++;
            end

            read_back(T_READ_LO[t], T_READ_HI[t]);

            if (test_errors != 0) tests_failed++;
            total_errors += test_errors;
            $display("test %0d: %0d words, session %0d, %s with %0d errors",
                     t, T_WORDS[t], T_SESSION[t], (test_errors == 0) ? "PASS" : "FAIL",
                     test_errors);
        end

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 NUM_TESTS, NUM_TESTS - tests_failed, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
src/loader_pkg.sv
src/word_assembler.sv
src/load_controller.sv
src/ram_memory.sv
src/program_loader_top.sv
verification/tb_program_loader.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the program loader testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log
SIM_BIN=sim_program_loader

rm -rf "$BUILD_DIR" "$LOG_FILE"

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_program_loader \
    --Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"

"./$BUILD_DIR/$SIM_BIN" | tee "$LOG_FILE"

if grep -q "Test failures found" "$LOG_FILE"; then
    echo "simulation reported failures, see $LOG_FILE"
    exit 1
fi

echo "simulation finished cleanly, log in $LOG_FILE"
